//--- design/frame_decoder_pkg.sv
package frame_decoder_pkg;

    typedef logic [47:0] link_word_t;   // One byte-reversed link word.
    typedef logic [23:0] word_len_t;    // Payload length in words.
    typedef logic [7:0]  byte_mask_t;
    typedef logic [2:0]  byte_cnt_t;    // Valid bytes in a word, 1 to 6.
    typedef logic [7:0]  link_byte_t;

    // Entry of the frame buffer. cnt holds the valid low bytes of word.
    typedef struct packed {
        logic       last;
        byte_cnt_t  cnt;
        link_word_t word;
    } buf_entry_t;

    typedef enum logic [1:0] {
        st_hunt,
        st_header,
        st_payload,
        st_eof
    } frame_state_t;

    localparam link_word_t SOF_WORD   = 48'hEA_FF_99_DE_AD_FF;
    localparam link_word_t EOF_WORD   = 48'hEA_FF_99_DE_AD_AA;
    localparam byte_cnt_t  WORD_BYTES = 3'd6;

endpackage

//--- design/frame_fsm.sv
`timescale 1ns/1ps

module frame_fsm import frame_decoder_pkg::*; (
    input  logic       rx_pixel_clk,
    input  logic       rst_n,
    input  link_word_t in_word,
    input  logic       in_valid,
    input  logic       last_word,
    input  logic       buf_full,
    output logic       load,
    output word_len_t  load_len,
    output logic       dec,
    output logic       wr_en,
    output buf_entry_t wr_entry,
    output logic       commit,
    output logic       discard
);

    frame_state_t state;
    frame_state_t state_nxt;
    byte_cnt_t    last_cnt;     // Byte count of the final payload word.
    byte_cnt_t    hdr_cnt;
    byte_mask_t   hdr_mask;
    logic         commit_nxt;
    logic         discard_nxt;

    // Header layout is app byte, length, mask, spare byte.
    assign hdr_mask = in_word[15:8];
    assign load_len = in_word[39:16];

    always_comb begin
        case (hdr_mask)
            8'd1:    hdr_cnt = 3'd1;
            8'd3:    hdr_cnt = 3'd2;
            8'd7:    hdr_cnt = 3'd3;
            8'd15:   hdr_cnt = 3'd4;
            8'd31:   hdr_cnt = 3'd5;
            default: hdr_cnt = WORD_BYTES;
        endcase
    end

    always_comb begin
        state_nxt     = state;
        load          = 1'b0;
        dec           = 1'b0;
        wr_en         = 1'b0;
        commit_nxt    = 1'b0;
        discard_nxt   = 1'b0;
        wr_entry.last = last_word;
        wr_entry.cnt  = last_word ? last_cnt : WORD_BYTES;
        wr_entry.word = in_word;
        if (in_valid) begin
            case (state)
                st_hunt: begin
                    if (in_word == SOF_WORD) state_nxt = st_header;
                end
                st_header: begin
                    if (load_len == '0) begin
                        state_nxt = st_eof;
                    end else begin
                        load      = 1'b1;
                        state_nxt = st_payload;
                    end
                end
                st_payload: begin
                    if (buf_full) begin
                        discard_nxt = 1'b1;     // Overflow drops the whole frame.
                        state_nxt   = st_hunt;
                    end else begin
                        wr_en = 1'b1;
                        dec   = 1'b1;
                        if (last_word) state_nxt = st_eof;
                    end
                end
                default: begin
                    commit_nxt  = (in_word == EOF_WORD);
                    discard_nxt = (in_word != EOF_WORD);
                    state_nxt   = st_hunt;
                end
            endcase
        end
    end

    always_ff @(posedge rx_pixel_clk) begin
        if (!rst_n) begin
            state    <= st_hunt;
            last_cnt <= WORD_BYTES;
            commit   <= 1'b0;
            discard  <= 1'b0;
        end else begin
            state   <= state_nxt;
            commit  <= commit_nxt;
            discard <= discard_nxt;
            if (in_valid && state == st_header) last_cnt <= hdr_cnt;
        end
    end

endmodule

//--- design/word_counter.sv
`timescale 1ns/1ps

module word_counter import frame_decoder_pkg::*; (
    input  logic      rx_pixel_clk,
    input  logic      rst_n,
    input  logic      load,
    input  word_len_t load_len,
    input  logic      dec,
    output logic      last_word
);

    word_len_t count;   // Payload words still expected.

    always_ff @(posedge rx_pixel_clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= load_len;
        end else if (dec) begin
            count <= count - 1'b1;
        end
    end

    assign last_word = (count == word_len_t'(1));

    // Header load and payload writes must stay in step with the FSM.
    a_no_underflow: assert property (@(posedge rx_pixel_clk) disable iff (!rst_n)
        dec && !load |-> count != '0);

endmodule

//--- design/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer import frame_decoder_pkg::*; #(
    parameter int BUF_ADDR_W = 6
) (
    input  logic       rx_pixel_clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  buf_entry_t wr_entry,
    input  logic       commit,
    input  logic       discard,
    input  logic       rd_en,
    output logic       buf_full,
    output logic       rd_avail,
    output buf_entry_t rd_entry
);

    localparam int DEPTH = 1 << BUF_ADDR_W;

    buf_entry_t mem [DEPTH];

    // Pointers carry one wrap bit above the address.
    logic [BUF_ADDR_W:0] wr_ptr;
    logic [BUF_ADDR_W:0] commit_ptr;
    logic [BUF_ADDR_W:0] rd_ptr;
    logic [BUF_ADDR_W:0] used;

    always_ff @(posedge rx_pixel_clk) begin
        if (wr_en) mem[wr_ptr[BUF_ADDR_W-1:0]] <= wr_entry;
    end

    always_ff @(posedge rx_pixel_clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
        end else begin
            if (discard) begin
                wr_ptr <= commit_ptr;   // Roll back the frame in progress.
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (commit) commit_ptr <= wr_ptr;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign used     = wr_ptr - rd_ptr;
    assign buf_full = used[BUF_ADDR_W];
    assign rd_avail = (commit_ptr != rd_ptr);
    assign rd_entry = mem[rd_ptr[BUF_ADDR_W-1:0]];

    a_rd_needs_avail: assert property (@(posedge rx_pixel_clk) disable iff (!rst_n)
        rd_en |-> rd_avail);

endmodule

//--- design/byte_unpacker.sv
`timescale 1ns/1ps

module byte_unpacker import frame_decoder_pkg::*; (
    input  logic       rx_pixel_clk,
    input  logic       rst_n,
    input  logic       rd_avail,
    input  buf_entry_t rd_entry,
    input  logic       full,
    output logic       rd_en,
    output logic       wr_en,
    output link_byte_t wr_byte
);

    link_word_t cur_word;
    byte_cnt_t  remain;     // Bytes of cur_word still to send, 0 when idle.
    byte_cnt_t  sel;
    link_word_t shifted;

    // Valid bytes sit at the bottom of the word, highest one goes out first.
    assign sel     = remain - 3'd1;
    assign shifted = cur_word >> {sel, 3'b000};
    assign wr_byte = shifted[7:0];

    assign wr_en = (remain != '0) && !full;
    assign rd_en = rd_avail && ((remain == '0) || (remain == 3'd1 && wr_en));

    always_ff @(posedge rx_pixel_clk) begin
        if (!rst_n) begin
            remain <= '0;
        end else if (rd_en) begin
            remain <= rd_entry.cnt;
        end else if (wr_en) begin
            remain <= remain - 3'd1;
        end
    end

    always_ff @(posedge rx_pixel_clk) begin
        if (rd_en) cur_word <= rd_entry.word;
    end

    // Only the closing word of a frame may be partial.
    a_partial_is_last: assert property (@(posedge rx_pixel_clk) disable iff (!rst_n)
        rd_en |-> (rd_entry.last || rd_entry.cnt == WORD_BYTES));

endmodule

//--- design/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo import frame_decoder_pkg::*; #(
    parameter int BYTE_ADDR_W = 5
) (
    input  logic       rx_pixel_clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  link_byte_t wr_byte,
    input  logic       byte_rd,
    output logic       full,
    output link_byte_t byte_data,
    output logic       byte_empty
);

    localparam int DEPTH = 1 << BYTE_ADDR_W;

    link_byte_t mem [DEPTH];

    logic [BYTE_ADDR_W-1:0] wr_ptr;
    logic [BYTE_ADDR_W-1:0] rd_ptr;
    logic [BYTE_ADDR_W:0]   count;

    always_ff @(posedge rx_pixel_clk) begin
        if (wr_en) mem[wr_ptr] <= wr_byte;
    end

    always_ff @(posedge rx_pixel_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (byte_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, byte_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full       = (count == DEPTH[BYTE_ADDR_W:0]);
    assign byte_empty = (count == '0);
    assign byte_data  = mem[rd_ptr];    // Show-ahead.

    a_no_overrun: assert property (@(posedge rx_pixel_clk) disable iff (!rst_n)
        wr_en |-> !full);

    a_no_underrun: assert property (@(posedge rx_pixel_clk) disable iff (!rst_n)
        byte_rd |-> !byte_empty);

endmodule

//--- design/frame_decoder_top.sv
`timescale 1ns/1ps

module frame_decoder_top import frame_decoder_pkg::*; #(
    parameter int BUF_ADDR_W  = 6,
    parameter int BYTE_ADDR_W = 5
) (
    input  logic        rx_pixel_clk,
    input  logic        rst_n,
    input  logic [63:0] rx_data,
    input  logic        rx_valid,
    input  logic        byte_rd,
    output link_byte_t  byte_data,
    output logic        byte_empty
);

    link_word_t in_word;
    logic       load;
    word_len_t  load_len;
    logic       dec;
    logic       last_word;
    logic       buf_wr_en;
    buf_entry_t wr_entry;
    logic       commit;
    logic       discard;
    logic       buf_full;
    logic       rd_en;
    logic       rd_avail;
    buf_entry_t rd_entry;
    logic       fifo_wr_en;
    link_byte_t wr_byte;
    logic       fifo_full;

    // Link sends the first byte in the lowest lane.
    assign in_word = {rx_data[7:0], rx_data[15:8], rx_data[23:16],
                      rx_data[31:24], rx_data[39:32], rx_data[47:40]};

    frame_fsm frame_fsm_i (
        .rx_pixel_clk (rx_pixel_clk),
        .rst_n        (rst_n),
        .in_word      (in_word),
        .in_valid     (rx_valid),
        .last_word    (last_word),
        .buf_full     (buf_full),
        .load         (load),
        .load_len     (load_len),
        .dec          (dec),
        .wr_en        (buf_wr_en),
        .wr_entry     (wr_entry),
        .commit       (commit),
        .discard      (discard)
    );

    word_counter word_counter_i (
        .rx_pixel_clk (rx_pixel_clk),
        .rst_n        (rst_n),
        .load         (load),
        .load_len     (load_len),
        .dec          (dec),
        .last_word    (last_word)
    );

    frame_buffer #(
        .BUF_ADDR_W (BUF_ADDR_W)
    ) frame_buffer_i (
        .rx_pixel_clk (rx_pixel_clk),
        .rst_n        (rst_n),
        .wr_en        (buf_wr_en),
        .wr_entry     (wr_entry),
        .commit       (commit),
        .discard      (discard),
        .rd_en        (rd_en),
        .buf_full     (buf_full),
        .rd_avail     (rd_avail),
        .rd_entry     (rd_entry)
    );

    byte_unpacker byte_unpacker_i (
        .rx_pixel_clk (rx_pixel_clk),
        .rst_n        (rst_n),
        .rd_avail     (rd_avail),
        .rd_entry     (rd_entry),
        .full         (fifo_full),
        .rd_en        (rd_en),
        .wr_en        (fifo_wr_en),
        .wr_byte      (wr_byte)
    );

    byte_fifo #(
        .BYTE_ADDR_W (BYTE_ADDR_W)
    ) byte_fifo_i (
        .rx_pixel_clk (rx_pixel_clk),
        .rst_n        (rst_n),
        .wr_en        (fifo_wr_en),
        .wr_byte      (wr_byte),
        .byte_rd      (byte_rd),
        .full         (fifo_full),
        .byte_data    (byte_data),
        .byte_empty   (byte_empty)
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    input  logic reset_req,     // Extra reset asked for by the stimulus.
    output logic rx_pixel_clk,
    output logic rst_n
);

    logic por;

    initial begin
        rx_pixel_clk = 1'b0;
        forever #(PERIOD_NS / 2) rx_pixel_clk = ~rx_pixel_clk;
    end

    // Power-on reset covers the first edges.
    initial begin
        por = 1'b1;
        repeat (RESET_CYCLES) @(posedge rx_pixel_clk);
        #1 por = 1'b0;
    end

    assign rst_n = !(por || reset_req);

endmodule

//--- verification/frame_decoder_tb.sv
`timescale 1ns/1ps

module frame_decoder_tb import frame_decoder_pkg::*; ();

    localparam int BUF_ADDR_W  = 6;
    localparam int BYTE_ADDR_W = 5;
    localparam int TIMEOUT     = 4000;

    logic        rx_pixel_clk;
    logic        rst_n;
    logic        reset_req;
    logic [63:0] rx_data;
    logic        rx_valid;
    logic        byte_rd;
    link_byte_t  byte_data;
    logic        byte_empty;
    logic        reader_on;         // Reader pops bytes only while set.
    logic        timed_out;
    logic [31:0] lfsr;
    link_byte_t  exp_q[$];          // Bytes of committed frames in arrival order.
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          test_err0 = 0;

    tb_clock_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (3)
    ) tb_clock_gen_i (
        .reset_req    (reset_req),
        .rx_pixel_clk (rx_pixel_clk),
        .rst_n        (rst_n)
    );

    frame_decoder_top #(
        .BUF_ADDR_W  (BUF_ADDR_W),
        .BYTE_ADDR_W (BYTE_ADDR_W)
    ) frame_decoder_top_i (
        .rx_pixel_clk (rx_pixel_clk),
        .rst_n        (rst_n),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .byte_rd      (byte_rd),
        .byte_data    (byte_data),
        .byte_empty   (byte_empty)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // Taps 32, 22, 2, 1.
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // Never a start marker, so it is harmless while the decoder hunts.
    function automatic link_word_t rand_word();
        logic [63:0] r;
        do begin
            r = rand_bits(48);
        end while (r[47:0] == SOF_WORD);
        return r[47:0];
    endfunction

    function automatic byte_mask_t rand_mask();
        logic [63:0] r;
        r = rand_bits(3);
        if (r < 5) return byte_mask_t'((1 << (r + 1)) - 1);
        r = rand_bits(8);
        return r[7:0];
    endfunction

    // A mask of k low ones keeps k bytes and any other mask keeps the whole word.
    function automatic int mask_bytes(input byte_mask_t m);
        int n;
        n = 6;
        for (int k = 1; k <= 5; k++) begin
            if (m == byte_mask_t'((1 << k) - 1)) n = k;
        end
        return n;
    endfunction

    function automatic logic [47:0] byte_swap(input link_word_t w);
        logic [47:0] r;
        for (int i = 0; i < 6; i++) r[i*8 +: 8] = w[(5-i)*8 +: 8];
        return r;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic tick();
        @(posedge rx_pixel_clk);
        #1;
    endtask

    task automatic send_word(input link_word_t w);
        logic [63:0] fill;
        fill = rand_bits(16);
        tick();
        rx_data  = {fill[15:0], byte_swap(w)};
        rx_valid = 1'b1;
    endtask

    task automatic idle_cycle();
        logic [63:0] junk;
        junk = rand_bits(64);
        tick();
        rx_data  = junk;
        rx_valid = 1'b0;
    endtask

    task automatic send_frame(input int len, input byte_mask_t mask, input bit eof_ok,
                              input bit gaps, input bit keep);
        link_word_t  w;
        logic [63:0] r;
        int          cnt;
        send_word(SOF_WORD);
        r = rand_bits(16);
        send_word({r[15:8], len[23:0], mask, r[7:0]});
        for (int k = 0; k < len; k++) begin
            if (gaps && rand_bits(2) == 0) idle_cycle();
            w = rand_word();
            send_word(w);
            cnt = (k == len - 1) ? mask_bytes(mask) : 6;
            for (int i = cnt - 1; i >= 0; i--) begin
                if (eof_ok && keep) exp_q.push_back(w[i*8 +: 8]);
            end
        end
        r = rand_bits(48);
        if (r[47:0] == EOF_WORD) r = ~r;
        send_word(eof_ok ? EOF_WORD : r[47:0]);
        idle_cycle();
    endtask

    task automatic set_reader(input logic on);
        @(posedge rx_pixel_clk);
        reader_on = on;
    endtask

    task automatic wait_reset_done();
        int n;
        n = 0;
        do begin
            tick();
            n++;
        end while (rst_n !== 1'b1 && n < TIMEOUT);
        if (rst_n !== 1'b1) begin
            timed_out = 1'b1;
            $display("Timeout: reset was never released");
        end
    endtask

    task automatic wait_not_empty();
        int n;
        n = 0;
        while (byte_empty && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (byte_empty) begin
            timed_out = 1'b1;
            $display("Timeout: no byte reached the output");
        end
    endtask

    // Done once nothing is outstanding and the output stays empty for a while.
    task automatic wait_drained();
        int n;
        int quiet;
        n = 0;
        quiet = 0;
        while (!timed_out && quiet < 20) begin
            tick();
            n++;
            quiet = (exp_q.size() == 0 && byte_empty) ? quiet + 1 : 0;
            if (n > TIMEOUT) begin
                timed_out = 1'b1;
                $display("Timeout: %0d expected bytes never came out", exp_q.size());
            end
        end
    endtask

    task automatic end_test(input string name);
        logic bad;
        bad = (errors != test_err0) || timed_out;
        tests_run++;
        if (bad) tests_bad++;
        $display("test %0d, %s: %s", tests_run, name, bad ? "errors" : "ok");
        test_err0 = errors;
    endtask

    // Downstream reader.
    initial begin
        byte_rd = 1'b0;
        forever begin
            @(posedge rx_pixel_clk);
            #1;
            byte_rd = reader_on && rst_n && !byte_empty;
            if (byte_rd) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected byte %h at %0t ns, no frame bytes outstanding",
                             byte_data, $time);
                end else begin
                    check_value(byte_data, exp_q.pop_front(), "payload byte");
                end
            end
        end
    end

    initial begin
        lfsr      = 32'h9ede;
        rx_data   = '0;
        rx_valid  = 1'b0;
        reset_req = 1'b0;
        reader_on = 1'b1;
        timed_out = 1'b0;
        wait_reset_done();

        for (int f = 0; f < 8; f++) send_frame(int'(rand_bits(3)) + 1, rand_mask(), 1, 0, 1);
        wait_drained();
        end_test("good frames");

        send_frame(3, rand_mask(), 1, 0, 1);
        send_frame(4, rand_mask(), 0, 0, 1);
        send_frame(2, rand_mask(), 1, 0, 1);
        wait_drained();
        end_test("bad end of frame");

        for (int f = 0; f < 5; f++) begin
            repeat (int'(rand_bits(2))) send_word(rand_word());
            idle_cycle();
            send_frame(int'(rand_bits(3)) + 1, rand_mask(), 1, 1, 1);
        end
        wait_drained();
        end_test("noise and gaps");

        send_frame(0, rand_mask(), 1, 0, 1);
        send_frame(int'(rand_bits(3)) + 1, rand_mask(), 1, 0, 1);
        wait_drained();
        end_test("zero length");

        // Seventy words fill the 64 buffer entries, five FIFO words and the one held.
        set_reader(1'b0);
        for (int f = 0; f < 14; f++) send_frame(5, 8'h00, 1, 0, 1);
        for (int f = 0; f < 2; f++) send_frame(3, rand_mask(), 1, 0, 0);
        set_reader(1'b1);
        wait_drained();
        send_frame(2, rand_mask(), 1, 0, 1);
        wait_drained();
        end_test("back-pressure");

        // Bytes of a committed frame sit in the output when the reset hits.
        set_reader(1'b0);
        send_frame(2, rand_mask(), 1, 0, 0);
        wait_not_empty();
        send_word(SOF_WORD);
        send_word({8'h00, 24'd4, 8'h00, 8'h00});
        send_word(rand_word());
        send_word(rand_word());
        idle_cycle();
        reset_req = 1'b1;
        repeat (3) tick();
        reset_req = 1'b0;
        check_value(byte_empty, 1, "byte_empty after reset");
        set_reader(1'b1);
        send_word(rand_word());
        send_word(rand_word());
        send_word(EOF_WORD);
        idle_cycle();
        send_frame(3, rand_mask(), 1, 0, 1);
        wait_drained();
        end_test("reset mid-frame");

        $display("%0d tests run, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0 && tests_bad == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- build.f
design/frame_decoder_pkg.sv
design/frame_fsm.sv
design/word_counter.sv
design/frame_buffer.sv
design/byte_unpacker.sv
design/byte_fifo.sv
design/frame_decoder_top.sv
verification/tb_clock_gen.sv
verification/frame_decoder_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
        --top-module frame_decoder_tb -f build.f -o frame_decoder_sim > compile.log 2>&1 \
    && ./obj_dir/frame_decoder_sim > sim.log 2>&1 ; \
cat sim.log 2>/dev/null ; \
grep -qx "test passed" sim.log \
    && echo "simulation run: PASS" \
    || { echo "simulation run: FAIL (see compile.log and sim.log)"; exit 1; }
